// File: common/rvMultiCycle_defs.svh
// ********************
// core-wide sizes and reset values
// ********************

`ifndef RV_MULTI_CYCLE_DEFS_SVH
`define RV_MULTI_CYCLE_DEFS_SVH

// data and address width
`define XLEN 32

`define RESET_PC 32'h0000_0000 // first fetch address

`define REG_COUNT 32

`endif

// File: common/rvIsaPkg.sv
// ********************
// RV32I ISA types: data word, major opcodes, ALU operations
// ********************

`include "rvMultiCycle_defs.svh"

package rvIsaPkg;

  typedef logic [`XLEN-1:0] data_t;

  // major opcodes, instr[6:0]
  typedef enum logic [6:0] {
    RType      = 7'b0110011,
    ITypeLogic = 7'b0010011,
    ITypeLoad  = 7'b0000011,
    SType      = 7'b0100011,
    BType      = 7'b1100011,
    JType      = 7'b1101111,
    ITypeJalr  = 7'b1100111,
    UTypeLui   = 7'b0110111,
    UTypeAuipc = 7'b0010111,
    Fence      = 7'b0001111
  } opcode_t;

  typedef enum logic [3:0] {
    ADD,
    SUB,
    SLL,
    SLT,
    SLTU,
    XOR,
    SRL,
    SRA,
    OR,
    AND
  } aluOp_t;

endpackage

// File: common/rvCtrlPkg.sv
// ********************
// control types: FSM states, datapath selects, control bundle
// ********************

package rvCtrlPkg;

  typedef enum logic [4:0] {
    FETCH, FETCH_WAIT, DECODE,
    EXECUTER, EXECUTEI, AUIPC, LUI,
    UNCONDJUMP, JALR_CALC, JALR_STEP2,
    MEMADR, MEMREAD, MEMWRITE, MEMWB,
    BRANCHIFEQ, BRANCHCOMP, ALUWB, HALT
  } state_t;

  typedef enum logic {ADR_SRC_PC, ADR_SRC_RESULT} adrSrc_t;

  typedef enum logic [1:0] {PC_SRC_INCREMENT, PC_SRC_JUMP, PC_SRC_ALU_RESULT} pcSrc_t;

  typedef enum logic [1:0] {ALU_SRC_A_RD1, ALU_SRC_A_OLD_PC, ALU_SRC_A_ZERO} aluSrcA_t;

  typedef enum logic [1:0] {ALU_SRC_B_RD2, ALU_SRC_B_IMM_EXT, ALU_SRC_B_FOUR} aluSrcB_t;

  typedef enum logic [1:0] {
    RESULT_SRC_ALU_OUT, RESULT_SRC_ALU_RESULT, RESULT_SRC_DATA
  } resultSrc_t;

  // add, decode from funct fields, or branch compare
  typedef enum logic [1:0] {ALU_MODE_ADD, ALU_MODE_FUNCT, ALU_MODE_BRANCH} aluMode_t;

  typedef struct packed {
    adrSrc_t    adrSrc;
    pcSrc_t     pcSrc;
    aluSrcA_t   aluSrcA;
    aluSrcB_t   aluSrcB;
    resultSrc_t resultSrc;
    aluMode_t   aluMode;
    logic       irWrite;
    logic       regWrite;
    logic       pcUpdate;
    logic [3:0] memWrite; // byte mask
  } ctrlSignals_t;

endpackage

// File: hw/datapath/regFile.sv
// ********************
// register file, 2 read / 1 write, x0 reads zero
// ********************

`timescale 1ns/10ps
`include "rvMultiCycle_defs.svh"

module regFile import rvIsaPkg::*; (
  input  logic                          clk,
  input  logic                          we,
  input  logic [$clog2(`REG_COUNT)-1:0] rs1,
  input  logic [$clog2(`REG_COUNT)-1:0] rs2,
  input  logic [$clog2(`REG_COUNT)-1:0] rd,
  input  data_t                         wd,
  output data_t                         rd1,
  output data_t                         rd2
);

  data_t regs [`REG_COUNT];

  always_ff @(posedge clk) begin
    if (we && rd != '0) regs[rd] <= wd;
  end

  assign rd1 = (rs1 == '0) ? '0 : regs[rs1];
  assign rd2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// File: hw/datapath/aluUnit.sv
// ********************
// ALU with operation decode from mode and funct fields
// ********************

`timescale 1ns/10ps

module aluUnit import rvIsaPkg::*, rvCtrlPkg::*; (
  input  aluMode_t   aluMode,
  input  logic [2:0] funct3,
  input  logic       funct7b5,
  input  logic       isRType,
  input  data_t      srcA,
  input  data_t      srcB,
  output data_t      result,
  output logic       zero
);

  aluOp_t op;

  always_comb begin
    case (aluMode)
      ALU_MODE_FUNCT: begin
        case (funct3)
          3'b000:  op = (isRType && funct7b5) ? SUB : ADD; // addi has no sub
          3'b001:  op = SLL;
          3'b010:  op = SLT;
          3'b011:  op = SLTU;
          3'b100:  op = XOR;
          3'b101:  op = funct7b5 ? SRA : SRL;
          3'b110:  op = OR;
          default: op = AND;
        endcase
      end
      ALU_MODE_BRANCH: op = !funct3[2] ? SUB : (funct3[1] ? SLTU : SLT);
      default:         op = ADD;
    endcase
  end

  always_comb begin
    case (op)
      SUB:     result = srcA - srcB;
      SLL:     result = srcA << srcB[4:0];
      SLT:     result = data_t'($signed(srcA) < $signed(srcB));
      SLTU:    result = data_t'(srcA < srcB);
      XOR:     result = srcA ^ srcB;
      SRL:     result = srcA >> srcB[4:0];
      SRA:     result = data_t'($signed(srcA) >>> srcB[4:0]);
      OR:      result = srcA | srcB;
      AND:     result = srcA & srcB;
      default: result = srcA + srcB;
    endcase
  end

  assign zero = (result == '0);

endmodule

// File: hw/datapath/rvDatapath.sv
// ********************
// shared datapath: PC and staging registers, immediates, muxes,
// store lane steering
// ********************

`timescale 1ns/10ps
`include "rvMultiCycle_defs.svh"

module rvDatapath import rvIsaPkg::*, rvCtrlPkg::*; (
  input  logic         clk,
  input  logic         reset,
  input  ctrlSignals_t ctrl,
  input  data_t        memRdata,
  output opcode_t      opcode,
  output logic [2:0]   funct3,
  output logic         zeroFlag,
  output logic         aluResultLsb,
  output logic [3:0]   byteEnable,
  output data_t        memAddr,
  output data_t        memWdata
);

  data_t pc, oldPc, ir, aReg, bReg, aluOut, dataReg;
  data_t rd1, rd2, immExt, srcA, srcB, aluResult, result, pcNext;

  assign opcode = opcode_t'(ir[6:0]);
  assign funct3 = ir[14:12];

  always_ff @(posedge clk) begin
    if (reset) pc <= `RESET_PC;
    else if (ctrl.pcUpdate) pc <= pcNext;
  end

  always_ff @(posedge clk) begin
    if (ctrl.irWrite) begin
      ir    <= memRdata;
      oldPc <= pc; // pc of the instruction being run
    end
    aReg    <= rd1;
    bReg    <= rd2;
    aluOut  <= aluResult;
    dataReg <= memRdata;
  end

  always_comb begin
    case (opcode)
      SType:                immExt = {{20{ir[31]}}, ir[31:25], ir[11:7]};
      BType:                immExt = {{19{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
      UTypeLui, UTypeAuipc: immExt = {ir[31:12], 12'b0};
      JType:                immExt = {{11{ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};
      default:              immExt = {{20{ir[31]}}, ir[31:20]};
    endcase
  end

  always_comb begin
    case (ctrl.aluSrcA)
      ALU_SRC_A_OLD_PC: srcA = oldPc;
      ALU_SRC_A_ZERO:   srcA = '0;
      default:          srcA = aReg;
    endcase
    case (ctrl.aluSrcB)
      ALU_SRC_B_IMM_EXT: srcB = immExt;
      ALU_SRC_B_FOUR:    srcB = 32'd4;
      default:           srcB = bReg;
    endcase
    case (ctrl.resultSrc)
      RESULT_SRC_ALU_RESULT: result = aluResult;
      RESULT_SRC_DATA:       result = dataReg;
      default:               result = aluOut;
    endcase
    case (ctrl.pcSrc)
      PC_SRC_JUMP:       pcNext = aluOut;
      PC_SRC_ALU_RESULT: pcNext = {aluOut[31:1], 1'b0}; // jalr target from JALR_CALC
      default:           pcNext = pc + 32'd4;
    endcase
  end

  assign memAddr = (ctrl.adrSrc == ADR_SRC_PC) ? pc : result;

  // store lanes follow the address held in ALU-out
  always_comb begin
    case (funct3)
      3'b000:  byteEnable = 4'b0001 << aluOut[1:0];
      3'b001:  byteEnable = 4'b0011 << {aluOut[1], 1'b0};
      default: byteEnable = 4'b1111;
    endcase
  end
  assign memWdata = bReg << {aluOut[1:0], 3'b000};

  aluUnit alu (
    .aluMode  (ctrl.aluMode),
    .funct3   (funct3),
    .funct7b5 (ir[30]),
    .isRType  (opcode == RType),
    .srcA     (srcA),
    .srcB     (srcB),
    .result   (aluResult),
    .zero     (zeroFlag)
  );
  assign aluResultLsb = aluResult[0];

  regFile rf (
    .clk (clk),
    .we  (ctrl.regWrite),
    .rs1 (ir[19:15]),
    .rs2 (ir[24:20]),
    .rd  (ir[11:7]),
    .wd  (result),
    .rd1 (rd1),
    .rd2 (rd2)
  );

endmodule

// File: hw/control/controlFsm.sv
// ********************
// control unit: Moore FSM stepping each instruction through the datapath
// ********************

`timescale 1ns/10ps

module controlFsm import rvIsaPkg::*, rvCtrlPkg::*; (
  input  logic         clk,
  input  logic         reset,
  input  opcode_t      opcode,
  input  logic [2:0]   funct3,
  input  logic         zeroFlag,
  input  logic         aluResultLsb,
  input  logic [3:0]   byteEnable,
  output ctrlSignals_t ctrl,
  output state_t       state,
  output logic         halted
);

  state_t nextState;

  always_comb begin
    case (state)
      FETCH:      nextState = FETCH_WAIT;
      FETCH_WAIT: nextState = DECODE;
      DECODE: begin
        case (opcode)
          RType:             nextState = EXECUTER;
          ITypeLogic:        nextState = EXECUTEI;
          ITypeLoad, SType:  nextState = MEMADR;
          BType:             nextState = funct3[2] ? BRANCHCOMP : BRANCHIFEQ;
          JType:             nextState = UNCONDJUMP;
          ITypeJalr:         nextState = JALR_CALC;
          UTypeLui:          nextState = LUI;
          UTypeAuipc:        nextState = AUIPC;
          Fence:             nextState = FETCH; // no-op
          default:           nextState = HALT;
        endcase
      end
      EXECUTER, EXECUTEI, AUIPC, LUI, UNCONDJUMP: nextState = ALUWB;
      JALR_CALC:  nextState = JALR_STEP2;
      JALR_STEP2: nextState = ALUWB;
      MEMADR:     nextState = (opcode == ITypeLoad) ? MEMREAD : MEMWRITE;
      MEMREAD:    nextState = MEMWB;
      HALT:       nextState = HALT; // only reset leaves
      default:    nextState = FETCH; // writeback, store and branch states
    endcase
  end

  always_comb begin
    ctrl.adrSrc    = ADR_SRC_PC;
    ctrl.pcSrc     = PC_SRC_INCREMENT;
    ctrl.aluSrcA   = ALU_SRC_A_RD1;
    ctrl.aluSrcB   = ALU_SRC_B_RD2;
    ctrl.resultSrc = RESULT_SRC_ALU_OUT;
    ctrl.aluMode   = ALU_MODE_ADD;
    ctrl.irWrite   = 1'b0;
    ctrl.regWrite  = 1'b0;
    ctrl.pcUpdate  = 1'b0;
    ctrl.memWrite  = 4'b0000;
    case (state)
      FETCH_WAIT: begin
        ctrl.irWrite  = 1'b1;
        ctrl.pcUpdate = 1'b1;
      end
      DECODE, AUIPC: begin // oldPc + imm, branch/jal target in decode
        ctrl.aluSrcA = ALU_SRC_A_OLD_PC;
        ctrl.aluSrcB = ALU_SRC_B_IMM_EXT;
      end
      LUI: begin
        ctrl.aluSrcA = ALU_SRC_A_ZERO;
        ctrl.aluSrcB = ALU_SRC_B_IMM_EXT;
      end
      EXECUTER: ctrl.aluMode = ALU_MODE_FUNCT;
      EXECUTEI: begin
        ctrl.aluSrcB = ALU_SRC_B_IMM_EXT;
        ctrl.aluMode = ALU_MODE_FUNCT;
      end
      UNCONDJUMP, JALR_STEP2: begin
        // link value oldPc + 4 goes to ALU-out for ALUWB
        ctrl.aluSrcA  = ALU_SRC_A_OLD_PC;
        ctrl.aluSrcB  = ALU_SRC_B_FOUR;
        ctrl.pcUpdate = 1'b1;
        ctrl.pcSrc    = (state == JALR_STEP2) ? PC_SRC_ALU_RESULT : PC_SRC_JUMP;
      end
      JALR_CALC: ctrl.aluSrcB = ALU_SRC_B_IMM_EXT;
      MEMADR: begin
        ctrl.aluSrcB   = ALU_SRC_B_IMM_EXT;
        ctrl.adrSrc    = ADR_SRC_RESULT;
        ctrl.resultSrc = RESULT_SRC_ALU_RESULT;
      end
      MEMREAD: ctrl.adrSrc = ADR_SRC_RESULT;
      MEMWRITE: begin
        ctrl.adrSrc   = ADR_SRC_RESULT;
        ctrl.memWrite = byteEnable;
      end
      BRANCHIFEQ, BRANCHCOMP: begin
        ctrl.aluMode = ALU_MODE_BRANCH;
        ctrl.pcSrc   = PC_SRC_JUMP;
        // funct3[0] inverts the sense (bne, bge, bgeu)
        if (state == BRANCHIFEQ) ctrl.pcUpdate = zeroFlag ^ funct3[0];
        else ctrl.pcUpdate = aluResultLsb ^ funct3[0];
      end
      ALUWB: ctrl.regWrite = 1'b1;
      MEMWB: begin
        ctrl.resultSrc = RESULT_SRC_DATA;
        ctrl.regWrite  = 1'b1;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) state <= FETCH;
    else state <= nextState;
  end

  assign halted = (state == HALT);

endmodule

// File: hw/rvMultiCycle.sv
// ********************
// multicycle RV32I core top, control unit beside datapath on one memory bus
// ********************

`timescale 1ns/10ps

module rvMultiCycle import rvIsaPkg::*, rvCtrlPkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  data_t      memRdata,
  output data_t      memAddr,
  output data_t      memWdata,
  output logic [3:0] memByteEn,
  output logic       halted
);

  ctrlSignals_t ctrl;
  state_t       state;
  opcode_t      opcode;
  logic [2:0]   funct3;
  logic         zeroFlag;
  logic         aluResultLsb;
  logic [3:0]   byteEnable;

  assign memByteEn = ctrl.memWrite; // nonzero only in MEMWRITE

  controlFsm control (
    .clk          (clk),
    .reset        (reset),
    .opcode       (opcode),
    .funct3       (funct3),
    .zeroFlag     (zeroFlag),
    .aluResultLsb (aluResultLsb),
    .byteEnable   (byteEnable),
    .ctrl         (ctrl),
    .state        (state),
    .halted       (halted)
  );

  rvDatapath datapath (
    .clk          (clk),
    .reset        (reset),
    .ctrl         (ctrl),
    .memRdata     (memRdata),
    .opcode       (opcode),
    .funct3       (funct3),
    .zeroFlag     (zeroFlag),
    .aluResultLsb (aluResultLsb),
    .byteEnable   (byteEnable),
    .memAddr      (memAddr),
    .memWdata     (memWdata)
  );

endmodule

// File: bench/rvMultiCycle_checker.sv
// ********************
// bound assertions on bus and control behavior
// ********************

`timescale 1ns/10ps

module rvMultiCycle_checker import rvIsaPkg::*, rvCtrlPkg::*; (
  input logic       clk,
  input logic       reset,
  input state_t     state,
  input logic [3:0] memByteEn,
  input logic       halted,
  input data_t      memAddr,
  input data_t      pc
);

  // bus writes happen in MEMWRITE and nowhere else
  writeOnlyInMemWrite: assert property (@(posedge clk) disable iff (reset)
    (memByteEn != 4'b0000) |-> (state == MEMWRITE))
    else $error("memByteEn active outside MEMWRITE");

  haltIsSticky: assert property (@(posedge clk) disable iff (reset)
    halted |=> halted)
    else $error("halted dropped without reset");

  stateKnown: assert property (@(posedge clk) disable iff (reset)
    !$isunknown(state))
    else $error("FSM state unknown");

  fetchUsesPc: assert property (@(posedge clk) disable iff (reset)
    (state == FETCH) |-> (memAddr == pc))
    else $error("fetch address differs from PC");

endmodule

bind rvMultiCycle rvMultiCycle_checker chk (
  .clk       (clk),
  .reset     (reset),
  .state     (state),
  .memByteEn (memByteEn),
  .halted    (halted),
  .memAddr   (memAddr),
  .pc        (datapath.pc)
);

// File: bench/rvMultiCycle_tb.sv
// ********************
// testbench with memory model, program table, store and halt checks
// ********************

`timescale 1ns/10ps

module rvMultiCycle_tb;

  localparam int NPROG = 6;
  localparam int MAXW = 40;
  localparam int MAXS = 16;
  localparam int TIMEOUT = 3000;

  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] data;
    logic [3:0]  mask;
  } storeEvt_t;

  logic        clk;
  logic        reset;
  logic [31:0] memRdata;
  logic [31:0] memAddr;
  logic [31:0] memWdata;
  logic [3:0]  memByteEn;
  logic        halted;

  logic [31:0] mem [256];
  logic [31:0] progWords [NPROG][MAXW];
  int          progLen [NPROG];
  storeEvt_t   expStores [NPROG][MAXS];
  int          expCount [NPROG];
  storeEvt_t   stores [$];
  int          cur;
  int          mismatches;
  int          otherFails;
  int          checks;
  bit          timedOut;

  rvMultiCycle u_dut (
    .clk       (clk),
    .reset     (reset),
    .memRdata  (memRdata),
    .memAddr   (memAddr),
    .memWdata  (memWdata),
    .memByteEn (memByteEn),
    .halted    (halted)
  );

  always #50 clk = ~clk;

  // byte-lane writes and reads registered one cycle after the address
  always @(posedge clk) begin
    for (int b = 0; b < 4; b++) begin
      if (memByteEn[b]) mem[memAddr[9:2]][8*b +: 8] <= memWdata[8*b +: 8];
    end
    memRdata <= mem[memAddr[9:2]];
    if (!reset && memByteEn != 4'b0000) stores.push_back({memAddr, memWdata, memByteEn});
  end

  function automatic logic [31:0] encR(int f7, int rs2, int rs1, int f3, int rd);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'h33};
  endfunction

  function automatic logic [31:0] encI(int imm, int rs1, int f3, int rd, int op);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
  endfunction

  function automatic logic [31:0] encS(int imm, int rs2, int rs1, int f3);
    return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], 7'h23};
  endfunction

  function automatic logic [31:0] encB(int imm, int rs2, int rs1, int f3);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'h63};
  endfunction

  function automatic logic [31:0] encU(int imm20, int rd, int op);
    return {imm20[19:0], rd[4:0], op[6:0]};
  endfunction

  function automatic logic [31:0] encJ(int imm, int rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'h6F};
  endfunction

  function automatic logic [31:0] laneMask(logic [3:0] m);
    return {{8{m[3]}}, {8{m[2]}}, {8{m[1]}}, {8{m[0]}}};
  endfunction

  task automatic put(logic [31:0] w);
    progWords[cur][progLen[cur]] = w;
    progLen[cur]++;
  endtask

  task automatic expectStore(logic [31:0] a, logic [31:0] d, logic [3:0] m);
    expStores[cur][expCount[cur]] = {a, d, m};
    expCount[cur]++;
  endtask

  task automatic buildTable;
    for (int p = 0; p < NPROG; p++) begin
      progLen[p] = 0;
      expCount[p] = 0;
    end
    // ALU ops with x1 = 100 and x2 = -7
    cur = 0;
    put(encI(512, 0, 0, 10, 7'h13));
    put(encI(100, 0, 0, 1, 7'h13));
    put(encI(-7, 0, 0, 2, 7'h13));
    put(encR(0, 2, 1, 0, 3));       put(encS(0, 3, 10, 2));
    expectStore(32'h200, 32'd93, 4'hF);
    put(encR(32, 2, 1, 0, 4));      put(encS(4, 4, 10, 2));
    expectStore(32'h204, 32'd107, 4'hF);
    put(encR(0, 1, 2, 2, 5));       put(encS(8, 5, 10, 2));
    expectStore(32'h208, 32'd1, 4'hF);
    put(encR(0, 1, 2, 3, 6));       put(encS(12, 6, 10, 2));
    expectStore(32'h20C, 32'd0, 4'hF);
    put(encR(0, 2, 1, 4, 7));       put(encS(16, 7, 10, 2));
    expectStore(32'h210, 32'hFFFFFF9D, 4'hF);
    put(encR(0, 2, 1, 6, 8));       put(encS(20, 8, 10, 2));
    expectStore(32'h214, 32'hFFFFFFFD, 4'hF);
    put(encR(0, 2, 1, 7, 9));       put(encS(24, 9, 10, 2));
    expectStore(32'h218, 32'h60, 4'hF);
    put(encI(3, 1, 1, 11, 7'h13));  put(encS(28, 11, 10, 2));
    expectStore(32'h21C, 32'd800, 4'hF);
    put(encI(32'h401, 2, 5, 12, 7'h13));
    put(encS(32, 12, 10, 2));
    expectStore(32'h220, 32'hFFFFFFFC, 4'hF); // srai of negative
    put(encI(28, 2, 5, 13, 7'h13)); put(encS(36, 13, 10, 2));
    expectStore(32'h224, 32'hF, 4'hF);
    put(encI(-1, 1, 4, 17, 7'h13)); put(encS(40, 17, 10, 2));
    expectStore(32'h228, 32'hFFFFFF9B, 4'hF);
    put(encI(-6, 2, 2, 18, 7'h13)); put(encS(44, 18, 10, 2));
    expectStore(32'h22C, 32'd1, 4'hF);
    put(encR(32, 3, 2, 5, 14));     put(encS(48, 14, 10, 2));
    expectStore(32'h230, 32'hFFFFFFFF, 4'hF);
    put(32'h0);
    // LUI and AUIPC
    cur = 1;
    put(encI(512, 0, 0, 10, 7'h13));
    put(encU(32'h12345, 1, 7'h37));
    put(encU(32'h00001, 2, 7'h17)); // at pc 8
    put(encS(0, 1, 10, 2));         expectStore(32'h200, 32'h12345000, 4'hF);
    put(encS(4, 2, 10, 2));         expectStore(32'h204, 32'h00001008, 4'hF);
    put(32'h0);
    // load after store, byte and half stores
    cur = 2;
    put(encI(512, 0, 0, 10, 7'h13));
    put(encU(32'hA1B2C, 1, 7'h37));
    put(encI(32'h3D4, 1, 0, 1, 7'h13));
    put(encS(0, 1, 10, 2));         expectStore(32'h200, 32'hA1B2C3D4, 4'hF);
    put(encI(0, 10, 2, 2, 7'h03));
    put(encS(4, 2, 10, 2));         expectStore(32'h204, 32'hA1B2C3D4, 4'hF);
    put(encS(8, 0, 10, 2));         expectStore(32'h208, 32'h0, 4'hF);
    put(encS(9, 1, 10, 0));         expectStore(32'h209, 32'h0000D400, 4'b0010);
    put(encS(14, 1, 10, 1));        expectStore(32'h20E, 32'hC3D40000, 4'b1100);
    put(encS(11, 1, 10, 0));        expectStore(32'h20B, 32'hD4000000, 4'b1000);
    put(encI(8, 10, 2, 3, 7'h03));
    put(encS(16, 3, 10, 2));        expectStore(32'h210, 32'hD400D400, 4'hF);
    put(32'h0);
    // marker stores run only where a branch falls through
    cur = 3;
    put(encI(512, 0, 0, 10, 7'h13));
    put(encI(5, 0, 0, 1, 7'h13));
    put(encI(-3, 0, 0, 2, 7'h13));
    put(encB(8, 1, 1, 0)); put(encS(0, 1, 10, 2));
    put(encB(8, 2, 1, 0)); put(encS(4, 1, 10, 2));  expectStore(32'h204, 32'd5, 4'hF);
    put(encB(8, 2, 1, 1)); put(encS(8, 1, 10, 2));
    put(encB(8, 1, 1, 1)); put(encS(12, 1, 10, 2)); expectStore(32'h20C, 32'd5, 4'hF);
    put(encB(8, 1, 2, 4)); put(encS(16, 1, 10, 2));
    put(encB(8, 2, 1, 4)); put(encS(20, 1, 10, 2)); expectStore(32'h214, 32'd5, 4'hF);
    put(encB(8, 2, 1, 5)); put(encS(24, 1, 10, 2));
    put(encB(8, 1, 2, 5)); put(encS(28, 1, 10, 2)); expectStore(32'h21C, 32'd5, 4'hF);
    put(encB(8, 2, 1, 6)); put(encS(32, 1, 10, 2));
    put(encB(8, 1, 2, 6)); put(encS(36, 1, 10, 2)); expectStore(32'h224, 32'd5, 4'hF);
    put(encB(8, 1, 2, 7)); put(encS(40, 1, 10, 2));
    put(encB(8, 2, 1, 7)); put(encS(44, 1, 10, 2)); expectStore(32'h22C, 32'd5, 4'hF);
    put(encB(8, 1, 1, 5)); put(encS(48, 1, 10, 2)); // bge on equal values
    put(encS(52, 2, 10, 2));        expectStore(32'h234, 32'hFFFFFFFD, 4'hF);
    put(32'h0);
    // JAL, JALR with odd target, FENCE
    cur = 4;
    put(encI(512, 0, 0, 10, 7'h13));
    put(encJ(12, 1));
    put(encS(0, 0, 10, 2));
    put(32'h0);
    put(encS(4, 1, 10, 2));         expectStore(32'h204, 32'd8, 4'hF);
    put(encI(41, 0, 0, 5, 7'h13));
    put(encI(0, 5, 0, 6, 7'h67));
    put(encS(8, 0, 10, 2));
    put(encS(12, 0, 10, 2));
    put(32'h0);
    put(encU(0, 7, 7'h17));         // auipc shows the landing pc
    put(encS(16, 6, 10, 2));        expectStore(32'h210, 32'd28, 4'hF);
    put(32'h0FF0000F);
    put(encS(20, 7, 10, 2));        expectStore(32'h214, 32'd40, 4'hF);
    put(32'h0);
    // unknown opcode halts before the last store
    cur = 5;
    put(encI(512, 0, 0, 10, 7'h13));
    put(encI(77, 0, 0, 1, 7'h13));
    put(encS(0, 1, 10, 2));         expectStore(32'h200, 32'd77, 4'hF);
    put(32'hFFFFFFFF);
    put(encS(4, 1, 10, 2));
    put(32'h0);
  endtask

  task automatic runProgram(int p);
    int cycles;
    @(posedge clk);
    reset <= 1'b1;
    repeat (3) @(posedge clk);
    @(negedge clk);
    for (int i = 0; i < 256; i++) mem[i] <= 32'h5A00_0000 | i;
    for (int w = 0; w < progLen[p]; w++) mem[w] <= progWords[p][w];
    checks++;
    assert (memAddr == 32'h0) else begin
      mismatches++;
      $display("Mismatch at %0t: program %0d fetch after reset at %h", $time, p, memAddr);
    end
    stores.delete();
    @(posedge clk);
    reset <= 1'b0;
    cycles = 0;
    while (!halted && cycles < TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    checks++;
    assert (halted) else begin
      otherFails++;
      timedOut = 1'b1;
      $display("Timeout: program %0d never reached halt", p);
    end
    repeat (4) @(negedge clk); // any late write would show up here
    checks++;
    assert (stores.size() == expCount[p]) else begin
      mismatches++;
      $display("Mismatch at %0t: program %0d made %0d stores, expected %0d",
               $time, p, stores.size(), expCount[p]);
    end
    for (int i = 0; i < stores.size() && i < expCount[p]; i++) begin
      checks++;
      assert (stores[i].addr == expStores[p][i].addr &&
              stores[i].mask == expStores[p][i].mask &&
              (stores[i].data & laneMask(stores[i].mask)) == expStores[p][i].data)
      else begin
        mismatches++;
        $display("Mismatch at %0t: program %0d store %0d got %h/%h/%b expected %h/%h/%b",
                 $time, p, i, stores[i].addr, stores[i].data, stores[i].mask,
                 expStores[p][i].addr, expStores[p][i].data, expStores[p][i].mask);
      end
    end
  endtask

  initial begin
    int seed;
    seed = 32'h7d85_ce77;
    clk = 1'b0;
    reset <= 1'b1;
    memRdata <= $random(seed);
    mismatches = 0;
    otherFails = 0;
    checks = 0;
    timedOut = 1'b0;
    buildTable();
    for (int p = 0; p < NPROG && !timedOut; p++) runProgram(p);
    $display("%0d checks, %0d mismatches, %0d other failures", checks, mismatches, otherFails);
    if (mismatches == 0 && otherFails == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// File: rvMultiCycle.f
+incdir+common
common/rvIsaPkg.sv
common/rvCtrlPkg.sv
hw/datapath/regFile.sv
hw/datapath/aluUnit.sv
hw/datapath/rvDatapath.sv
hw/control/controlFsm.sv
hw/rvMultiCycle.sv
bench/rvMultiCycle_checker.sv
bench/rvMultiCycle_tb.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f rvMultiCycle.f --top-module rvMultiCycle_tb \
  -o VrvMultiCycle_tb

./obj_dir/VrvMultiCycle_tb 2>&1 | tee sim.log

if grep -q "Checks failed" sim.log || ! grep -q "All checks passed" sim.log; then
  echo "simulation FAILED"
  exit 1
fi
echo "simulation ok"
